// File: hdl/desc_channel.sv
// one descriptor channel; rewriting fields while desc_valid is high changes the pending descriptor
`include "dma_ctrl_cfg.svh"

module desc_channel (
    input  logic                       clk,
    input  logic                       rst,
    input  dma_ctrl_pkg::chan_wr_t     wr,
    input  logic                       pop,
    output dma_ctrl_pkg::dma_desc_t    desc,
    output logic                       desc_valid,
    input  logic                       desc_ready,
    input  dma_ctrl_pkg::desc_status_t status,
    output logic                       status_ready,
    output logic [31:0]                status_word
);

    logic launch;

    assign launch = wr.stb && (wr.op == dma_ctrl_pkg::TAG_LAUNCH);

    // field registers, written one 32-bit word at a time
    always_ff @(posedge clk) begin
        if (wr.stb) begin
            case (wr.op)
                dma_ctrl_pkg::PCIE_LO: begin
                    desc.pcie_addr[31:0] <= wr.data;
                end
                dma_ctrl_pkg::PCIE_HI: begin
                    desc.pcie_addr[`DMA_PCIE_ADDR_W-1:32] <= wr.data;
                end
                dma_ctrl_pkg::AXI_ADDR: begin
                    desc.axi_addr <= wr.data[`DMA_AXI_ADDR_W-1:0];
                end
                dma_ctrl_pkg::LEN: begin
                    desc.len <= wr.data[`DMA_LEN_W-1:0];
                end
                dma_ctrl_pkg::TAG_LAUNCH: begin
                    desc.tag <= wr.data[`DMA_TAG_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // a launch wins over a handshake in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid <= 1'b0;
        end else if (launch) begin
            desc_valid <= 1'b1;
        end else if (desc_ready) begin
            desc_valid <= 1'b0;
        end
    end

    // completion pops only when one is actually pending
    assign status_ready = pop && status.valid;

    always_comb begin
        status_word = 32'd0;
        status_word[`DMA_TAG_W-1:0] = status.tag;
        status_word[`DMA_STATUS_VALID_BIT] = status.valid;
    end

endmodule

// File: hdl/dma_ctrl_cfg.svh
// widths and register offsets are fixed at build time; offsets are byte addresses of 32-bit words
`ifndef DMA_CTRL_CFG_SVH
`define DMA_CTRL_CFG_SVH

// bus and descriptor field widths
`define DMA_APB_ADDR_W 16
`define DMA_PCIE_ADDR_W 64
`define DMA_AXI_ADDR_W 32
`define DMA_LEN_W 16
`define DMA_TAG_W 8

// register map
`define DMA_REG_ENABLE 16'h0000
`define DMA_REG_RD_BASE 16'h0100
`define DMA_REG_WR_BASE 16'h0200
`define DMA_REG_CNT_BASE 16'h0400

// each channel owns a 0x100 window, offsets are the low byte
`define DMA_CHAN_WIN_W 8

// status word layout, tag sits in the low bits
`define DMA_STATUS_VALID_BIT 31

`endif

// File: hdl/dma_ctrl_pkg.sv
// shared bus, descriptor and counter types; field widths come from the cfg header
`include "dma_ctrl_cfg.svh"

package dma_ctrl_pkg;

    typedef struct packed {
        logic                       sel;
        logic                       enable;
        logic                       write;
        logic [`DMA_APB_ADDR_W-1:0] addr;
        logic [31:0]                wdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
    } apb_rsp_t;

    typedef struct packed {
        logic [`DMA_PCIE_ADDR_W-1:0] pcie_addr;
        logic [`DMA_AXI_ADDR_W-1:0]  axi_addr;
        logic [`DMA_LEN_W-1:0]       len;
        logic [`DMA_TAG_W-1:0]       tag;
    } dma_desc_t;

    typedef struct packed {
        logic [`DMA_TAG_W-1:0] tag;
        logic                  valid;
    } desc_status_t;

    // channel register offsets within its window
    typedef enum logic [`DMA_CHAN_WIN_W-1:0] {
        PCIE_LO    = 8'h00,
        PCIE_HI    = 8'h04,
        AXI_ADDR   = 8'h08,
        LEN        = 8'h10,
        TAG_LAUNCH = 8'h14,
        STATUS     = 8'h18
    } desc_reg_e;

    typedef struct packed {
        logic        stb;
        desc_reg_e   op;
        logic [31:0] data;
    } chan_wr_t;

    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } strm_tap_t;

    typedef struct packed {
        strm_tap_t rq;
        strm_tap_t rc;
        strm_tap_t cq;
        strm_tap_t cc;
    } tlp_taps_t;

    typedef struct packed {
        logic [31:0] rq;
        logic [31:0] rc;
        logic [31:0] cq;
        logic [31:0] cc;
    } tlp_counts_t;

    typedef enum logic {
        SETUP  = 1'b0,
        ACCESS = 1'b1
    } apb_phase_e;

endpackage

// File: hdl/dma_ctrl_top.sv
// DMA control plane; status sources must hold each completion until status_ready
module dma_ctrl_top (
    input  logic                       clk,
    input  logic                       rst,
    input  dma_ctrl_pkg::apb_req_t     apb_req,
    output dma_ctrl_pkg::apb_rsp_t     apb_rsp,
    output dma_ctrl_pkg::dma_desc_t    rd_desc,
    output logic                       rd_desc_valid,
    input  logic                       rd_desc_ready,
    input  dma_ctrl_pkg::desc_status_t rd_status,
    output logic                       rd_status_ready,
    output dma_ctrl_pkg::dma_desc_t    wr_desc,
    output logic                       wr_desc_valid,
    input  logic                       wr_desc_ready,
    input  dma_ctrl_pkg::desc_status_t wr_status,
    output logic                       wr_status_ready,
    input  dma_ctrl_pkg::tlp_taps_t    taps,
    output logic                       dma_enable,
    output logic                       irq
);

    dma_ctrl_pkg::chan_wr_t    rd_wr;
    dma_ctrl_pkg::chan_wr_t    wr_wr;
    logic                      rd_pop;
    logic                      wr_pop;
    logic [31:0]               rd_status_word;
    logic [31:0]               wr_status_word;
    dma_ctrl_pkg::tlp_counts_t counts;

    dma_reg_apb u_regs (
        .clk            (clk),
        .rst            (rst),
        .req            (apb_req),
        .rsp            (apb_rsp),
        .rd_wr          (rd_wr),
        .wr_wr          (wr_wr),
        .rd_pop         (rd_pop),
        .wr_pop         (wr_pop),
        .rd_status_word (rd_status_word),
        .wr_status_word (wr_status_word),
        .counts         (counts),
        .dma_enable     (dma_enable),
        .irq            (irq)
    );

    // host to card reads
    desc_channel u_rd_chan (
        .clk          (clk),
        .rst          (rst),
        .wr           (rd_wr),
        .pop          (rd_pop),
        .desc         (rd_desc),
        .desc_valid   (rd_desc_valid),
        .desc_ready   (rd_desc_ready),
        .status       (rd_status),
        .status_ready (rd_status_ready),
        .status_word  (rd_status_word)
    );

    desc_channel u_wr_chan (
        .clk          (clk),
        .rst          (rst),
        .wr           (wr_wr),
        .pop          (wr_pop),
        .desc         (wr_desc),
        .desc_valid   (wr_desc_valid),
        .desc_ready   (wr_desc_ready),
        .status       (wr_status),
        .status_ready (wr_status_ready),
        .status_word  (wr_status_word)
    );

    tlp_counters u_counters (
        .clk    (clk),
        .rst    (rst),
        .taps   (taps),
        .counts (counts)
    );

endmodule

// File: hdl/dma_reg_apb.sv
// APB slave with zero wait states and no error response; address bits 1:0 are ignored
`include "dma_ctrl_cfg.svh"

module dma_reg_apb (
    input  logic                      clk,
    input  logic                      rst,
    input  dma_ctrl_pkg::apb_req_t    req,
    output dma_ctrl_pkg::apb_rsp_t    rsp,
    output dma_ctrl_pkg::chan_wr_t    rd_wr,
    output dma_ctrl_pkg::chan_wr_t    wr_wr,
    output logic                      rd_pop,
    output logic                      wr_pop,
    input  logic [31:0]               rd_status_word,
    input  logic [31:0]               wr_status_word,
    input  dma_ctrl_pkg::tlp_counts_t counts,
    output logic                      dma_enable,
    output logic                      irq
);

    dma_ctrl_pkg::apb_phase_e phase;

    logic                        access;
    logic                        wr_acc;
    logic                        rd_acc;
    logic [`DMA_APB_ADDR_W-1:0]  word_addr;
    logic [`DMA_APB_ADDR_W-1:0]  win_base;
    logic [`DMA_CHAN_WIN_W-1:0]  offset;
    logic                        in_rd;
    logic                        in_wr;

    // setup cycle is always followed by access
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= dma_ctrl_pkg::SETUP;
        end else if (req.sel && !req.enable) begin
            phase <= dma_ctrl_pkg::ACCESS;
        end else begin
            phase <= dma_ctrl_pkg::SETUP;
        end
    end

    assign access = req.sel && req.enable && (phase == dma_ctrl_pkg::ACCESS);
    assign wr_acc = access && req.write;
    assign rd_acc = access && !req.write;

    assign word_addr = {req.addr[`DMA_APB_ADDR_W-1:2], 2'b00};
    assign win_base  = {req.addr[`DMA_APB_ADDR_W-1:`DMA_CHAN_WIN_W], `DMA_CHAN_WIN_W'(0)};
    assign offset    = word_addr[`DMA_CHAN_WIN_W-1:0];
    assign in_rd     = (win_base == `DMA_REG_RD_BASE);
    assign in_wr     = (win_base == `DMA_REG_WR_BASE);

    // channel write ports, opcode is the word offset in the window
    always_comb begin
        rd_wr.stb  = wr_acc && in_rd;
        rd_wr.op   = dma_ctrl_pkg::desc_reg_e'(offset);
        rd_wr.data = req.wdata;
        wr_wr.stb  = wr_acc && in_wr;
        wr_wr.op   = dma_ctrl_pkg::desc_reg_e'(offset);
        wr_wr.data = req.wdata;
    end

    assign rd_pop = rd_acc && in_rd && (offset == dma_ctrl_pkg::STATUS);
    assign wr_pop = rd_acc && in_wr && (offset == dma_ctrl_pkg::STATUS);

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_enable <= 1'b0;
        end else if (wr_acc && (word_addr == `DMA_REG_ENABLE)) begin
            dma_enable <= req.wdata[0];
        end
    end

    // read data straight from the registers, zero when unmapped
    always_comb begin
        rsp.ready = req.sel && req.enable;
        rsp.rdata = 32'd0;
        case (word_addr)
            `DMA_REG_ENABLE: rsp.rdata = {31'd0, dma_enable};
            `DMA_REG_RD_BASE + 16'(dma_ctrl_pkg::STATUS): rsp.rdata = rd_status_word;
            `DMA_REG_WR_BASE + 16'(dma_ctrl_pkg::STATUS): rsp.rdata = wr_status_word;
            `DMA_REG_CNT_BASE + 16'h0000: rsp.rdata = counts.rq;
            `DMA_REG_CNT_BASE + 16'h0004: rsp.rdata = counts.rc;
            `DMA_REG_CNT_BASE + 16'h0008: rsp.rdata = counts.cq;
            `DMA_REG_CNT_BASE + 16'h000c: rsp.rdata = counts.cc;
            default: rsp.rdata = 32'd0;
        endcase
    end

    // level interrupt while any completion is pending
    assign irq = rd_status_word[`DMA_STATUS_VALID_BIT] || wr_status_word[`DMA_STATUS_VALID_BIT];

endmodule

// File: hdl/tlp_counters.sv
// packet counters wrap at 2^32 and count one per final beat accepted on each tap
module tlp_counters (
    input  logic                      clk,
    input  logic                      rst,
    input  dma_ctrl_pkg::tlp_taps_t   taps,
    output dma_ctrl_pkg::tlp_counts_t counts
);

    // last beat of a packet handed over
    function automatic logic pkt_done(input dma_ctrl_pkg::strm_tap_t t);
        return t.valid && t.ready && t.last;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            if (pkt_done(taps.rq)) begin
                counts.rq <= counts.rq + 32'd1;
            end
            if (pkt_done(taps.rc)) begin
                counts.rc <= counts.rc + 32'd1;
            end
            if (pkt_done(taps.cq)) begin
                counts.cq <= counts.cq + 32'd1;
            end
            if (pkt_done(taps.cc)) begin
                counts.cc <= counts.cc + 32'd1;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_dma_ctrl -f sources.f -o tb_dma_ctrl
./obj_dir/tb_dma_ctrl

// File: sources.f
+incdir+hdl
hdl/dma_ctrl_pkg.sv
hdl/desc_channel.sv
hdl/tlp_counters.sv
hdl/dma_reg_apb.sv
hdl/dma_ctrl_top.sv
tests/clk_gen.sv
tests/tb_dma_ctrl.sv

// File: tests/clk_gen.sv
// 20 time-unit clock; rst is high for the first four rising edges and drops on a falling edge
module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tests/tb_dma_ctrl.sv
// self-checking; inputs change on falling edges and outputs are sampled mid low phase
`include "dma_ctrl_cfg.svh"

module tb_dma_ctrl;

    // whole sequence takes roughly 350 cycles
    localparam int MAX_CYCLES = 3000;
    localparam int SAMPLE_DLY = 5;
    localparam logic [`DMA_APB_ADDR_W-1:0] STATUS_OFF = 16'h0018;

    logic                       clk;
    logic                       rst;
    dma_ctrl_pkg::apb_req_t     apb_req;
    dma_ctrl_pkg::apb_rsp_t     apb_rsp;
    dma_ctrl_pkg::dma_desc_t    rd_desc;
    dma_ctrl_pkg::dma_desc_t    wr_desc;
    logic                       rd_desc_valid;
    logic                       wr_desc_valid;
    logic                       rd_desc_ready;
    logic                       wr_desc_ready;
    dma_ctrl_pkg::desc_status_t rd_status;
    dma_ctrl_pkg::desc_status_t wr_status;
    logic                       rd_status_ready;
    logic                       wr_status_ready;
    dma_ctrl_pkg::tlp_taps_t    taps;
    logic                       dma_enable;
    logic                       irq;

    // reference model of the register map
    logic                       m_enable;
    logic                       m_rd_valid;
    logic                       m_wr_valid;
    dma_ctrl_pkg::dma_desc_t    m_rd_desc;
    dma_ctrl_pkg::dma_desc_t    m_wr_desc;
    dma_ctrl_pkg::tlp_counts_t  m_counts;
    logic [31:0]                rng;
    int                         cycles = 0;
    string                      test_name;
    logic [`DMA_APB_ADDR_W-1:0] word_addr;
    logic                       wr_access;
    logic                       rd_access;
    logic                       in_rd;
    logic                       in_wr;

    clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    dma_ctrl_top i_dma_ctrl_top (.*);

    assign word_addr = {apb_req.addr[`DMA_APB_ADDR_W-1:2], 2'b00};
    assign wr_access = apb_req.sel && apb_req.enable && apb_req.write;
    assign rd_access = apb_req.sel && apb_req.enable && !apb_req.write;
    assign in_rd     = ({apb_req.addr[15:8], 8'h00} == `DMA_REG_RD_BASE);
    assign in_wr     = ({apb_req.addr[15:8], 8'h00} == `DMA_REG_WR_BASE);

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic dma_ctrl_pkg::dma_desc_t desc_after_write(
        input dma_ctrl_pkg::dma_desc_t d, input logic [7:0] off, input logic [31:0] data);
        dma_ctrl_pkg::dma_desc_t n;
        n = d;
        case (off)
            8'h00: n.pcie_addr[31:0] = data;
            8'h04: n.pcie_addr[63:32] = data;
            8'h08: n.axi_addr = data;
            8'h10: n.len = data[15:0];
            8'h14: n.tag = data[7:0];
            default: n = d;
        endcase
        return n;
    endfunction

    function automatic logic next_valid(input logic valid, input logic launch, input logic ready);
        return launch ? 1'b1 : (valid && !ready);
    endfunction

    function automatic logic [31:0] final_beat(input dma_ctrl_pkg::strm_tap_t t);
        return {31'd0, (t.valid && t.ready && t.last)};
    endfunction

    // expected APB read data where write-only and unmapped words read 0
    function automatic logic [31:0] expected_read(input logic [`DMA_APB_ADDR_W-1:0] addr);
        case (addr)
            `DMA_REG_ENABLE: return {31'd0, m_enable};
            `DMA_REG_RD_BASE + STATUS_OFF: return {rd_status.valid, 23'd0, rd_status.tag};
            `DMA_REG_WR_BASE + STATUS_OFF: return {wr_status.valid, 23'd0, wr_status.tag};
            `DMA_REG_CNT_BASE + 16'h0000: return m_counts.rq;
            `DMA_REG_CNT_BASE + 16'h0004: return m_counts.rc;
            `DMA_REG_CNT_BASE + 16'h0008: return m_counts.cq;
            `DMA_REG_CNT_BASE + 16'h000c: return m_counts.cc;
            default: return 32'd0;
        endcase
    endfunction

    // model advances on the same edge as the DUT using only testbench-driven inputs
    always @(posedge clk) begin
        if (rst) begin
            m_enable   <= 1'b0;
            m_rd_valid <= 1'b0;
            m_wr_valid <= 1'b0;
            m_counts   <= '0;
        end else begin
            if (wr_access && (word_addr == `DMA_REG_ENABLE)) begin
                m_enable <= apb_req.wdata[0];
            end
            if (wr_access && in_rd) begin
                m_rd_desc <= desc_after_write(m_rd_desc, word_addr[7:0], apb_req.wdata);
            end
            if (wr_access && in_wr) begin
                m_wr_desc <= desc_after_write(m_wr_desc, word_addr[7:0], apb_req.wdata);
            end
            m_rd_valid <= next_valid(m_rd_valid, wr_access && in_rd && word_addr[7:0] == 8'h14,
                                     rd_desc_ready);
            m_wr_valid <= next_valid(m_wr_valid, wr_access && in_wr && word_addr[7:0] == 8'h14,
                                     wr_desc_ready);
            m_counts.rq <= m_counts.rq + final_beat(taps.rq);
            m_counts.rc <= m_counts.rc + final_beat(taps.rc);
            m_counts.cq <= m_counts.cq + final_beat(taps.cq);
            m_counts.cc <= m_counts.cc + final_beat(taps.cc);
        end
    end

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic compare_data(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic compare_desc(input string what, input dma_ctrl_pkg::dma_desc_t exp,
                                input dma_ctrl_pkg::dma_desc_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs();
        logic rd_pop;
        logic wr_pop;
        rd_pop = rd_access && (word_addr == `DMA_REG_RD_BASE + STATUS_OFF);
        wr_pop = rd_access && (word_addr == `DMA_REG_WR_BASE + STATUS_OFF);
        compare_bit("dma_enable", m_enable, dma_enable);
        compare_bit("irq", rd_status.valid || wr_status.valid, irq);
        compare_bit("rd_desc_valid", m_rd_valid, rd_desc_valid);
        compare_bit("wr_desc_valid", m_wr_valid, wr_desc_valid);
        compare_bit("rd_status_ready", rd_pop && rd_status.valid, rd_status_ready);
        compare_bit("wr_status_ready", wr_pop && wr_status.valid, wr_status_ready);
        if (m_rd_valid) begin
            compare_desc("rd_desc", m_rd_desc, rd_desc);
        end
        if (m_wr_valid) begin
            compare_desc("wr_desc", m_wr_desc, wr_desc);
        end
        if (apb_req.sel && apb_req.enable) begin
            compare_bit("apb ready", 1'b1, apb_rsp.ready);
        end
        if (rd_access) begin
            compare_data("read data", expected_read(word_addr), apb_rsp.rdata);
        end
    endtask

    always @(negedge clk) begin
        #SAMPLE_DLY;
        if (!rst) begin
            check_outputs();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    // one setup and one access cycle followed by an idle cycle
    task automatic apb_xfer(input logic write, input logic [`DMA_APB_ADDR_W-1:0] addr,
                            input logic [31:0] data);
        @(negedge clk);
        apb_req.sel    = 1'b1;
        apb_req.enable = 1'b0;
        apb_req.write  = write;
        apb_req.addr   = addr;
        apb_req.wdata  = data;
        @(negedge clk);
        apb_req.enable = 1'b1;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic read_counters();
        for (int i = 0; i < 4; i++) begin
            apb_xfer(1'b0, `DMA_REG_CNT_BASE + 16'(4 * i), 32'd0);
        end
    endtask

    task automatic launch_and_drain(input logic is_wr);
        logic [`DMA_APB_ADDR_W-1:0] base;
        dma_ctrl_pkg::dma_desc_t    d;
        logic [31:0]                r;
        base = is_wr ? `DMA_REG_WR_BASE : `DMA_REG_RD_BASE;
        d.pcie_addr = {xorshift32(), xorshift32()};
        d.axi_addr = xorshift32();
        r = xorshift32();
        d.len = r[15:0];
        d.tag = r[23:16];
        apb_xfer(1'b1, base + 16'h0000, d.pcie_addr[31:0]);
        apb_xfer(1'b1, base + 16'h0004, d.pcie_addr[63:32]);
        apb_xfer(1'b1, base + 16'h0008, d.axi_addr);
        apb_xfer(1'b1, base + 16'h0010, {16'd0, d.len});
        apb_xfer(1'b1, base + 16'h0014, {24'd0, d.tag});
        compare_bit("launched valid", 1'b1, is_wr ? wr_desc_valid : rd_desc_valid);
        compare_desc("launched fields", d, is_wr ? wr_desc : rd_desc);
        // idle channel's consumer stays ready so a crossed clear would show
        if (is_wr) begin
            rd_desc_ready = 1'b1;
        end else begin
            wr_desc_ready = 1'b1;
        end
        // back-pressure for a random stretch
        repeat (2 + int'(r[27:24])) @(negedge clk);
        if (is_wr) begin
            wr_desc_ready = 1'b1;
        end else begin
            rd_desc_ready = 1'b1;
        end
        @(negedge clk);
        wr_desc_ready = 1'b0;
        rd_desc_ready = 1'b0;
        @(negedge clk);
    endtask

    task automatic pop_status(input logic is_wr);
        logic [`DMA_APB_ADDR_W-1:0] addr;
        dma_ctrl_pkg::desc_status_t s;
        logic [31:0]                r;
        addr = (is_wr ? `DMA_REG_WR_BASE : `DMA_REG_RD_BASE) + STATUS_OFF;
        r = xorshift32();
        s.tag = r[7:0];
        s.valid = 1'b1;
        @(negedge clk);
        if (is_wr) begin
            wr_status = s;
        end else begin
            rd_status = s;
        end
        apb_xfer(1'b0, addr, 32'd0);
        // source releases the completion once it has been popped
        if (is_wr) begin
            wr_status = '0;
        end else begin
            rd_status = '0;
        end
        apb_xfer(1'b0, addr, 32'd0);
    endtask

    task automatic random_taps(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(negedge clk);
            r = xorshift32();
            taps = r[11:0];
        end
        @(negedge clk);
        taps = '0;
    endtask

    initial begin
        apb_req = '0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status = '0;
        wr_status = '0;
        taps = '0;
        rng = 32'he4fc0bd9;
        test_name = "reset";
        wait (rst == 1'b0);
        read_counters();
        apb_xfer(1'b0, `DMA_REG_ENABLE, 32'd0);
        test_name = "enable";
        apb_xfer(1'b1, `DMA_REG_ENABLE, 32'hffff_ffff);
        apb_xfer(1'b0, `DMA_REG_ENABLE, 32'd0);
        apb_xfer(1'b1, `DMA_REG_ENABLE, 32'h0000_0000);
        apb_xfer(1'b0, `DMA_REG_ENABLE, 32'd0);
        apb_xfer(1'b1, `DMA_REG_ENABLE, 32'd1);
        test_name = "read channel";
        launch_and_drain(1'b0);
        test_name = "write channel";
        launch_and_drain(1'b1);
        test_name = "status";
        pop_status(1'b0);
        pop_status(1'b1);
        test_name = "counters";
        random_taps(200);
        read_counters();
        test_name = "unmapped";
        apb_xfer(1'b0, 16'h0004, 32'd0);
        apb_xfer(1'b0, 16'h0108, 32'd0);
        apb_xfer(1'b0, 16'h0300, 32'd0);
        apb_xfer(1'b0, 16'h0410, 32'd0);
        apb_xfer(1'b0, 16'hfffc, 32'd0);
        repeat (2) @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule
